// ==== mem_stage.f ====
rtl/mem_stage_pkg.sv
rtl/mem_request.sv
rtl/data_memory.sv
rtl/memory_stage.sv
rtl/load_extract.sv
rtl/mem_stage_top.sv
sim/mem_stage_check.sv
sim/mem_stage_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the memory stage testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
  --top-module mem_stage_tb \
  -f mem_stage.f \
  --Mdir obj_dir \
  -o mem_stage_sim

./obj_dir/mem_stage_sim

// ==== sim/mem_stage_tb.sv ====
`timescale 1ns/100ps

module mem_stage_tb;
  import mem_stage_pkg::*;

  localparam int depth_log2 = 10;
  localparam int wait_cycles = 2;
  localparam int num_instr = 400;
  localparam int init_words = 16;
  localparam int watchdog_ns = (num_instr * (wait_cycles + 2) + 200) * 8;

  logic clock;
  logic reset;
  logic flush;
  execute_out_t exe;
  logic stall;
  writeback_t wb;
  logic failed;

  mem_stage_top #(
    .depth_log2(depth_log2),
    .wait_cycles(wait_cycles)
  ) dut (
    .clock(clock),
    .reset(reset),
    .flush(flush),
    .exe(exe),
    .stall(stall),
    .wb(wb)
  );

  mem_stage_check #(
    .wait_cycles(wait_cycles)
  ) u_check (
    .clock(clock),
    .reset(reset),
    .flush(flush),
    .exe(exe),
    .stall(stall),
    .wb(wb),
    .failed(failed)
  );

  task automatic stop_with_failure(input string why);
    $display("Something failed");
    $fatal(1, "%s", why);
  endtask

  // The first instructions fill the 16 word window with word stores.
  function automatic execute_out_t make_instr(int index);
    execute_out_t e;
    int kind;
    int size;
    int word;
    int off;
    e = '0;
    e.valid = 1'b1;
    e.pc = 32'h0000_1000 + 32'(index) * 4;
    e.waddr = 5'(int'($urandom % 31) + 1);
    e.wdata = $urandom;
    e.sdata = $urandom;
    kind = (index < init_words) ? 9 : int'($urandom % 10);
    word = (index < init_words) ? index : int'($urandom % 16);
    off = (index < init_words) ? 0 : int'($urandom % 4);
    case (kind)
      2: e.lsu_op.lsu_lb = 1'b1;
      3: e.lsu_op.lsu_lbu = 1'b1;
      4: e.lsu_op.lsu_lh = 1'b1;
      5: e.lsu_op.lsu_lhu = 1'b1;
      6: e.lsu_op.lsu_lw = 1'b1;
      7: e.lsu_op.lsu_sb = 1'b1;
      8: e.lsu_op.lsu_sh = 1'b1;
      9: e.lsu_op.lsu_sw = 1'b1;
      default: e.lsu_op = '0;
    endcase
    e.load = (kind >= 2) && (kind <= 6);
    e.store = kind >= 7;
    e.wren = e.load || (!e.store && ($urandom % 2 == 0));
    size = (kind == 6 || kind == 9) ? 4 : ((kind == 4 || kind == 5 || kind == 8) ? 2 : 1);
    // Mostly aligned, now and then misaligned on purpose.
    if ($urandom % 5 != 0) begin
      off = off - off % size;
    end
    e.address = 32'h0000_0200 + 32'(word * 4 + off);
    if (index >= init_words && $urandom % 25 == 0) begin
      e.exception = 1'b1;
      e.ecause = 4'd2;
    end
    return e;
  endfunction

  always #4 clock = ~clock;

  initial begin
    #(watchdog_ns);
    stop_with_failure("watchdog expired before all instructions were issued");
  end

  always @(posedge failed) begin
    stop_with_failure("a check in the checker reported a mismatch");
  end

  // **********************************************************************
  // Stimulus, changed on the falling edge only.
  // **********************************************************************

  initial begin
    execute_out_t cur;
    int issued;
    logic have;
    void'($urandom(65));
    clock = 1'b0;
    reset = 1'b1;
    flush = 1'b0;
    exe = '0;
    issued = 0;
    have = 1'b0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    while (issued < num_instr) begin
      if (!have) begin
        cur = make_instr(issued);
        have = 1'b1;
      end
      flush = (issued >= init_words) && ($urandom % 16 == 0);
      exe = cur;
      if (flush) begin
        exe.valid = 1'b0;
      end
      @(posedge clock);
      // Held on exe until the stage takes it.
      if (exe.valid && !stall && !flush) begin
        issued++;
        have = 1'b0;
      end
      @(negedge clock);
    end
    flush = 1'b0;
    exe = '0;
    repeat (wait_cycles + 4) @(posedge clock);
    if (failed) begin
      stop_with_failure("a mismatch was reported before the end of the run");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

// ==== sim/mem_stage_check.sv ====
`timescale 1ns/100ps

module mem_stage_check #(
  parameter int wait_cycles = 2
) (
  input logic clock,
  input logic reset,
  input logic flush,
  input mem_stage_pkg::execute_out_t exe,
  input logic stall,
  input mem_stage_pkg::writeback_t wb,
  output logic failed
);
  import mem_stage_pkg::*;

  localparam logic [3:0] load_misaligned_code = 4'd4;
  localparam logic [3:0] store_misaligned_code = 4'd6;

  logic [31:0] model_mem [16];
  writeback_t wb_exp;
  writeback_t slot_item;
  logic slot_valid;
  int slot_left;
  logic stall_exp;
  logic reset_seen = 1'b0;

  initial failed = 1'b0;

  task automatic report(input string name, input logic [63:0] expected,
                        input logic [63:0] actual);
    $display("** Error %s: expected %h, actual %h", name, expected, actual);
    failed = 1'b1;
  endtask

  function automatic int access_size(lsu_op_t op);
    if (op.lsu_lw || op.lsu_sw) begin
      return 4;
    end
    if (op.lsu_lh || op.lsu_lhu || op.lsu_sh) begin
      return 2;
    end
    return 1;
  endfunction

  function automatic logic misaligned(execute_out_t e);
    int off;
    off = int'(e.address[1:0]);
    return (e.load || e.store) && (off % access_size(e.lsu_op) != 0);
  endfunction

  function automatic logic is_access(execute_out_t e);
    return (e.load || e.store) && !e.exception && !misaligned(e);
  endfunction

  function automatic logic [31:0] loaded_value(logic [31:0] word, execute_out_t e);
    int off;
    logic [31:0] value;
    off = int'(e.address[1:0]);
    if (e.lsu_op.lsu_lw) begin
      value = word;
    end else if (e.lsu_op.lsu_lh || e.lsu_op.lsu_lhu) begin
      value = {16'h0000, word[8*off +: 16]};
      if (e.lsu_op.lsu_lh && value[15]) begin
        value[31:16] = 16'hffff;
      end
    end else begin
      value = {24'h000000, word[8*off +: 8]};
      if (e.lsu_op.lsu_lb && value[7]) begin
        value[31:8] = 24'hffffff;
      end
    end
    return value;
  endfunction

  function automatic logic [31:0] stored_word(logic [31:0] word, execute_out_t e);
    int off;
    logic [31:0] result;
    off = int'(e.address[1:0]);
    result = word;
    for (int k = 0; k < access_size(e.lsu_op); k++) begin
      result[8*(off+k) +: 8] = e.sdata[8*k +: 8];
    end
    return result;
  endfunction

  function automatic writeback_t expected_item(execute_out_t e, logic [31:0] word);
    writeback_t item;
    item = '0;
    item.valid = 1'b1;
    item.exception = e.exception || misaligned(e);
    if (e.exception) begin
      item.ecause = e.ecause;
    end else if (e.load) begin
      item.ecause = load_misaligned_code;
    end else begin
      item.ecause = store_misaligned_code;
    end
    item.wren = e.wren && !item.exception;
    item.waddr = e.waddr;
    item.epc = e.pc;
    item.wdata = (e.load && is_access(e)) ? loaded_value(word, e) : e.wdata;
    return item;
  endfunction

  // **********************************************************************
  // Pipeline model: one slot, held while its access waits.
  // **********************************************************************

  assign stall_exp = slot_valid && (slot_left > 0) && !flush;

  always @(posedge clock) begin
    reset_seen <= reset;
    if (reset || flush) begin
      slot_valid <= 1'b0;
      slot_left <= 0;
      wb_exp <= '0;
    end else if (slot_valid && slot_left > 0) begin
      slot_left <= slot_left - 1;
      wb_exp <= '0;
    end else begin
      wb_exp <= slot_valid ? slot_item : '0;
      slot_valid <= exe.valid;
      slot_item <= expected_item(exe, model_mem[exe.address[5:2]]);
      slot_left <= is_access(exe) ? wait_cycles : 0;
      if (exe.valid && exe.store && is_access(exe)) begin
        model_mem[exe.address[5:2]] <= stored_word(model_mem[exe.address[5:2]], exe);
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clock) reset_seen |-> !stall && !wb.valid)
    else report("reset_quiet", 64'(0), 64'({$sampled(stall), $sampled(wb.valid)}));

  a_stall: assert property (@(posedge clock) disable iff (reset) stall == stall_exp)
    else report("stall", 64'($sampled(stall_exp)), 64'($sampled(stall)));

  a_wb_valid: assert property (@(posedge clock) disable iff (reset)
    wb.valid == wb_exp.valid)
    else report("wb_valid", 64'($sampled(wb_exp.valid)), 64'($sampled(wb.valid)));

  a_wb_wdata: assert property (@(posedge clock) disable iff (reset)
    wb_exp.valid |-> wb.wdata == wb_exp.wdata)
    else report("wb_wdata", 64'($sampled(wb_exp.wdata)), 64'($sampled(wb.wdata)));

  a_wb_dest: assert property (@(posedge clock) disable iff (reset)
    wb_exp.valid |-> wb.wren == wb_exp.wren && wb.waddr == wb_exp.waddr)
    else report("wb_dest", 64'({$sampled(wb_exp.wren), $sampled(wb_exp.waddr)}),
                64'({$sampled(wb.wren), $sampled(wb.waddr)}));

  a_wb_exception: assert property (@(posedge clock) disable iff (reset)
    wb_exp.valid |-> wb.exception == wb_exp.exception &&
                     (!wb_exp.exception || wb.ecause == wb_exp.ecause))
    else report("wb_exception", 64'({$sampled(wb_exp.exception), $sampled(wb_exp.ecause)}),
                64'({$sampled(wb.exception), $sampled(wb.ecause)}));

  a_wb_epc: assert property (@(posedge clock) disable iff (reset)
    wb_exp.valid |-> wb.epc == wb_exp.epc)
    else report("wb_epc", 64'($sampled(wb_exp.epc)), 64'($sampled(wb.epc)));

endmodule

// ==== rtl/mem_stage_top.sv ====
`timescale 1ns/100ps

module mem_stage_top #(
  parameter int depth_log2 = 10,
  parameter int wait_cycles = 2
) (
  input logic clock,
  input logic reset,
  input logic flush,
  input mem_stage_pkg::execute_out_t exe,
  output logic stall,
  output mem_stage_pkg::writeback_t wb
);
  import mem_stage_pkg::*;

  mem_request_t mem_req;
  mem_response_t mem_rsp;
  stage_entry_t entry;
  load_in_t load_in;
  logic [xlen-1:0] load_result;

  mem_request u_mem_request (
    .exe(exe),
    .mem_req(mem_req),
    .entry(entry)
  );

  data_memory #(
    .depth_log2(depth_log2),
    .wait_cycles(wait_cycles)
  ) u_data_memory (
    .clock(clock),
    .reset(reset),
    .flush(flush),
    .mem_req(mem_req),
    .mem_rsp(mem_rsp)
  );

  memory_stage u_memory_stage (
    .clock(clock),
    .reset(reset),
    .flush(flush),
    .entry(entry),
    .mem_rsp(mem_rsp),
    .load_result(load_result),
    .load_in(load_in),
    .stall(stall),
    .wb(wb)
  );

  load_extract u_load_extract (
    .load_in(load_in),
    .load_result(load_result)
  );

endmodule

// ==== rtl/load_extract.sv ====
`timescale 1ns/100ps

module load_extract (
  input mem_stage_pkg::load_in_t load_in,
  output logic [mem_stage_pkg::xlen-1:0] load_result
);
  import mem_stage_pkg::*;

  logic [xlen-1:0] shifted;

  // Addressed byte or halfword moved down to bit 0.
  assign shifted = load_in.rdata >> {load_in.byte_offset, 3'b000};

  always_comb begin
    if (load_in.lsu_op.lsu_lb) begin
      load_result = {{(xlen-8){shifted[7]}}, shifted[7:0]};
    end else if (load_in.lsu_op.lsu_lbu) begin
      load_result = {{(xlen-8){1'b0}}, shifted[7:0]};
    end else if (load_in.lsu_op.lsu_lh) begin
      load_result = {{(xlen-16){shifted[15]}}, shifted[15:0]};
    end else if (load_in.lsu_op.lsu_lhu) begin
      load_result = {{(xlen-16){1'b0}}, shifted[15:0]};
    end else if (load_in.lsu_op.lsu_lw) begin
      load_result = load_in.rdata;
    end else begin
      load_result = '0;
    end
  end

  // Opcode is one-hot or empty.
  always_comb begin
    assert ($countones(load_in.lsu_op) <= 1)
      else $error("load_extract: lsu_op %b has more than one bit set", load_in.lsu_op);
  end

endmodule

// ==== rtl/memory_stage.sv ====
`timescale 1ns/100ps

module memory_stage (
  input logic clock,
  input logic reset,
  input logic flush,
  input mem_stage_pkg::stage_entry_t entry,
  input mem_stage_pkg::mem_response_t mem_rsp,
  input logic [mem_stage_pkg::xlen-1:0] load_result,
  output mem_stage_pkg::load_in_t load_in,
  output logic stall,
  output mem_stage_pkg::writeback_t wb
);
  import mem_stage_pkg::*;

  stage_entry_t r;
  stage_entry_t r_next;
  writeback_t wb_next;

  // **********************************************************************
  // Stall and next stage contents.
  // **********************************************************************

  // An access waits for ready; a flush releases it at once.
  assign stall = r.valid & r.access & ~mem_rsp.ready & ~flush;

  always_comb begin
    if (stall) begin
      r_next = r;
    end else begin
      r_next = entry;
    end
    if (flush) begin
      r_next.valid = 1'b0;
      r_next.access = 1'b0;
      r_next.load = 1'b0;
      r_next.wren = 1'b0;
      r_next.exception = 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      r.valid <= 1'b0;
      r.access <= 1'b0;
      r.load <= 1'b0;
      r.wren <= 1'b0;
      r.exception <= 1'b0;
      r.lsu_op <= '0;
    end else begin
      r <= r_next;
    end
  end

  // **********************************************************************
  // Load formatting request.
  // **********************************************************************

  assign load_in.rdata = mem_rsp.rdata;
  assign load_in.byte_offset = r.byte_offset;
  assign load_in.lsu_op = r.lsu_op;

  // **********************************************************************
  // Writeback item.
  // **********************************************************************

  always_comb begin
    wb_next.valid = r.valid;
    wb_next.wren = r.wren;
    wb_next.waddr = r.waddr;
    wb_next.exception = r.exception;
    wb_next.ecause = r.ecause;
    wb_next.epc = r.pc;
    if (r.load & r.access) begin
      wb_next.wdata = load_result;
    end else begin
      wb_next.wdata = r.wdata;
    end
    // Nothing leaves the stage while waiting or when squashed.
    if (stall | flush | ~r.valid) begin
      wb_next = '0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wb.valid <= 1'b0;
      wb.wren <= 1'b0;
      wb.exception <= 1'b0;
    end else begin
      wb <= wb_next;
    end
  end

  // **********************************************************************
  // Checks.
  // **********************************************************************

  // A flush leaves the stage empty in the next cycle.
  a_no_stall_on_flush: assert property (
    @(posedge clock) disable iff (reset)
    flush |=> !stall
  );

  // Stall only holds an access taken in the cycle before or already waiting.
  a_no_stall_when_empty: assert property (
    @(posedge clock) disable iff (reset)
    stall |-> $past(stall || entry.access)
  );

endmodule

// ==== rtl/data_memory.sv ====
`timescale 1ns/100ps

module data_memory #(
  parameter int depth_log2 = 10,
  parameter int wait_cycles = 2
) (
  input logic clock,
  input logic reset,
  input logic flush,
  input mem_stage_pkg::mem_request_t mem_req,
  output mem_stage_pkg::mem_response_t mem_rsp
);
  import mem_stage_pkg::*;

  localparam int count_bits = (wait_cycles > 0) ? $clog2(wait_cycles + 1) : 1;

  logic [xlen-1:0] mem [2**depth_log2];

  logic busy;
  logic [count_bits-1:0] count;
  logic [depth_log2-1:0] addr_q;
  logic [depth_log2-1:0] req_index;
  logic ready;
  logic accept;

  // **********************************************************************
  // Access control.
  // **********************************************************************

  assign ready = busy & (count == '0);
  assign req_index = mem_req.addr[depth_log2-1:0];

  // A new request is taken when idle or in the ready cycle of the last one.
  assign accept = mem_req.valid & ~flush & (~busy | ready);

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= 1'b0;
      count <= '0;
    end else if (flush) begin
      // Pending access is dropped.
      busy <= 1'b0;
      count <= '0;
    end else if (accept) begin
      busy <= 1'b1;
      count <= count_bits'(wait_cycles);
    end else if (ready) begin
      busy <= 1'b0;
    end else if (busy) begin
      count <= count - 1'b1;
    end
  end

  // **********************************************************************
  // Storage.
  // **********************************************************************

  always_ff @(posedge clock) begin
    if (accept) begin
      addr_q <= req_index;
      for (int i = 0; i < 4; i++) begin
        if (mem_req.wstrb[i]) begin
          mem[req_index][i*8 +: 8] <= mem_req.wdata[i*8 +: 8];
        end
      end
    end
  end

  assign mem_rsp.ready = ready;
  assign mem_rsp.rdata = mem[addr_q];

  // Ready only answers the access accepted wait_cycles + 1 cycles before.
  a_ready_after_accept: assert property (
    @(posedge clock) disable iff (reset)
    mem_rsp.ready |-> $past(accept, wait_cycles + 1)
  );

endmodule

// ==== rtl/mem_request.sv ====
`timescale 1ns/100ps

module mem_request (
  input mem_stage_pkg::execute_out_t exe,
  output mem_stage_pkg::mem_request_t mem_req,
  output mem_stage_pkg::stage_entry_t entry
);
  import mem_stage_pkg::*;

  logic [1:0] offset;
  logic half;
  logic word;
  logic misaligned;
  logic is_mem;
  logic fault;

  assign offset = exe.address[1:0];
  assign half = exe.lsu_op.lsu_lh | exe.lsu_op.lsu_lhu | exe.lsu_op.lsu_sh;
  assign word = exe.lsu_op.lsu_lw | exe.lsu_op.lsu_sw;

  // Halfwords need bit 0 clear, words need both low bits clear.
  assign misaligned = (half & offset[0]) | (word & (offset != 2'b00));
  assign is_mem = exe.valid & (exe.load | exe.store);
  assign fault = is_mem & misaligned & ~exe.exception;

  always_comb begin
    mem_req.valid = is_mem & ~misaligned & ~exe.exception;
    mem_req.addr = exe.address[xlen-1:2];

    // Store data replicated over every lane, strobes pick the lanes.
    mem_req.wdata = exe.sdata;
    mem_req.wstrb = 4'b0000;
    if (exe.store) begin
      if (exe.lsu_op.lsu_sb) begin
        mem_req.wdata = {4{exe.sdata[7:0]}};
        mem_req.wstrb = 4'b0001 << offset;
      end else if (exe.lsu_op.lsu_sh) begin
        mem_req.wdata = {2{exe.sdata[15:0]}};
        mem_req.wstrb = 4'b0011 << offset;
      end else if (exe.lsu_op.lsu_sw) begin
        mem_req.wstrb = 4'b1111;
      end
    end

    entry.valid = exe.valid;
    entry.pc = exe.pc;
    entry.access = mem_req.valid;
    entry.load = exe.valid & exe.load;
    entry.waddr = exe.waddr;
    entry.wdata = exe.wdata;
    entry.byte_offset = offset;
    entry.lsu_op = exe.lsu_op;
    entry.exception = exe.valid & (exe.exception | fault);
    if (exe.exception) begin
      entry.ecause = exe.ecause;
    end else if (exe.load) begin
      entry.ecause = cause_load_misaligned;
    end else begin
      entry.ecause = cause_store_misaligned;
    end
    // A trapping instruction never writes the register file.
    entry.wren = exe.valid & exe.wren & ~entry.exception;
  end

endmodule

// ==== rtl/mem_stage_pkg.sv ====
package mem_stage_pkg;

  // Data and address width of the integer pipeline.
  localparam int xlen = 32;

  // Exception causes raised by the memory stage.
  localparam logic [3:0] cause_load_misaligned = 4'd4;
  localparam logic [3:0] cause_store_misaligned = 4'd6;

  // **********************************************************************
  // Load/store opcode, one bit per operation.
  // **********************************************************************

  typedef struct packed {
    logic lsu_lb;
    logic lsu_lbu;
    logic lsu_lh;
    logic lsu_lhu;
    logic lsu_lw;
    logic lsu_sb;
    logic lsu_sh;
    logic lsu_sw;
  } lsu_op_t;

  // **********************************************************************
  // Pipeline items.
  // **********************************************************************

  typedef struct packed {
    logic valid;
    logic [xlen-1:0] pc;
    logic load;
    logic store;
    logic wren;
    logic [4:0] waddr;
    logic [xlen-1:0] wdata;
    logic [xlen-1:0] address;
    logic [xlen-1:0] sdata;
    lsu_op_t lsu_op;
    logic exception;
    logic [3:0] ecause;
  } execute_out_t;

  typedef struct packed {
    logic valid;
    logic [xlen-1:0] pc;
    logic access;
    logic load;
    logic wren;
    logic [4:0] waddr;
    logic [xlen-1:0] wdata;
    logic [1:0] byte_offset;
    lsu_op_t lsu_op;
    logic exception;
    logic [3:0] ecause;
  } stage_entry_t;

  // Word addressed request; a zero strobe is a read.
  typedef struct packed {
    logic valid;
    logic [xlen-3:0] addr;
    logic [xlen-1:0] wdata;
    logic [3:0] wstrb;
  } mem_request_t;

  typedef struct packed {
    logic ready;
    logic [xlen-1:0] rdata;
  } mem_response_t;

  typedef struct packed {
    logic [xlen-1:0] rdata;
    logic [1:0] byte_offset;
    lsu_op_t lsu_op;
  } load_in_t;

  typedef struct packed {
    logic valid;
    logic wren;
    logic [4:0] waddr;
    logic [xlen-1:0] wdata;
    logic exception;
    logic [3:0] ecause;
    logic [xlen-1:0] epc;
  } writeback_t;

endpackage
